/* Makefile */
VERILATOR ?= verilator
TOP       ?= conv_tb
FLIST     ?= conv_accel.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := $(wildcard source/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* conv_accel.f */
+incdir+source
source/conv_pkg.sv
source/conv_ctrl.sv
source/kernel_mem.sv
source/window_buffer.sv
source/mac_array.sv
source/conv_top.sv
dv/conv_tb.sv

/* dv/conv_tb.sv */
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_tb;

  localparam int NOCH      = `CONV_NUM_OCH;
  localparam int TAPS      = `CONV_TAPS;
  localparam int CENTRE    = `CONV_TAPS / 2;
  localparam int NUM_TESTS = 5;

  // Kernel selections
  localparam int K_IDENT = 0; // Centre tap scaled by channel + 1
  localparam int K_RAND  = 1; // Small random weights
  localparam int K_LARGE = 2; // Drives the sums past the 16-bit range
  localparam int K_RAMP  = 3;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  conv_pkg::in_beat_t  in_beat;
  logic                out_valid;
  conv_pkg::out_beat_t out_beat;

  // Test table with one column per field
  string test_name [NUM_TESTS] = '{"identity", "random_small", "saturation",
                                   "kernel_reload", "identity_again"};
  int    test_ksel [NUM_TESTS] = '{K_IDENT, K_RAND, K_LARGE, K_RAMP, K_IDENT};
  int    test_nwin [NUM_TESTS] = '{2, 6, 2, 4, 2};
  bit    test_rand [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  int    test_lit  [NUM_TESTS] = '{0, 0, 2, 0, 0}; // First literal window row
  int    test_kpre [NUM_TESTS] = '{0, 0, 0, 14, 0}; // Partial kernel beats before the load

  // Literal windows in tap order
  conv_pkg::data_t lit_win [4][TAPS] = '{
    '{16'sd10, -16'sd20, 16'sd30, -16'sd40, 16'sd55, 16'sd60, -16'sd70, 16'sd80, -16'sd90},
    '{16'sd7, 16'sd7, 16'sd7, 16'sd7, -16'sd1234, 16'sd7, 16'sd7, 16'sd7, 16'sd7},
    '{16'sd1000, 16'sd1000, 16'sd1000, 16'sd1000, 16'sd1000,
      16'sd1000, 16'sd1000, 16'sd1000, 16'sd1000},
    '{-16'sd1000, -16'sd1000, -16'sd1000, -16'sd1000, -16'sd1000,
      -16'sd1000, -16'sd1000, -16'sd1000, -16'sd1000}
  };

  conv_pkg::data_t     kern [NOCH][TAPS];
  conv_pkg::data_t     feat [TAPS];
  conv_pkg::out_beat_t exp_q[$];
  int                  exp_test_q[$];

  int errors        = 0;
  int checks        = 0;
  int windows_sent  = 0;
  int windows_done  = 0;
  int out_cnt       = 0;
  int cycle_cnt     = 0;
  int limit_cycles  = 0;

  conv_top i_conv_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic conv_pkg::data_t clamp_to_data(input longint v);
    if (v > 32767) return 16'sh7fff;
    if (v < -32768) return 16'sh8000;
    return conv_pkg::data_t'(v);
  endfunction

  // Reference convolution for one channel
  function automatic conv_pkg::data_t expected_sum(input int o);
    longint s;
    s = 0;
    for (int t = 0; t < TAPS; t++) begin
      s += longint'(feat[t]) * longint'(kern[o][t]);
    end
    return clamp_to_data(s);
  endfunction

  function automatic int cycle_budget();
    int b;
    b = 8 + 40; // Reset and the idle check
    for (int i = 0; i < NUM_TESTS; i++) begin
      b += NOCH * TAPS + 40 + test_nwin[i] * (TAPS + TAPS + NOCH + 20);
      if (test_kpre[i] > 0) begin
        b += test_kpre[i] + 40 + TAPS + TAPS + NOCH + 20;
      end
    end
    return b;
  endfunction

  task automatic build_kernel(input int ksel);
    for (int o = 0; o < NOCH; o++) begin
      for (int t = 0; t < TAPS; t++) begin
        case (ksel)
          K_IDENT: kern[o][t] = (t == CENTRE) ? conv_pkg::data_t'(o + 1) : '0;
          K_RAND:  kern[o][t] = conv_pkg::data_t'(int'($urandom_range(15, 0)) - 8);
          K_LARGE: begin
            case (o)
              0:       kern[o][t] = 16'sd1000;
              1:       kern[o][t] = -16'sd1000;
              2:       kern[o][t] = 16'sd3;  // Stays inside the range
              default: kern[o][t] = 16'sd4;  // Just over 32767
            endcase
          end
          default: kern[o][t] = conv_pkg::data_t'((o + 1) * (t - CENTRE));
        endcase
      end
    end
  endtask

  task automatic build_window(input int ti, input int w);
    for (int t = 0; t < TAPS; t++) begin
      if (test_rand[ti]) begin
        feat[t] = conv_pkg::data_t'(int'($urandom_range(400, 0)) - 200);
      end else begin
        feat[t] = lit_win[test_lit[ti] + w][t];
      end
    end
  endtask

  task automatic drive_beat(input conv_pkg::beat_kind_t kind, input conv_pkg::data_t v);
    @(negedge clk);
    in_valid     = 1'b1;
    in_beat.kind = kind;
    in_beat.data = v;
  endtask

  task automatic release_bus();
    @(negedge clk);
    in_valid = 1'b0;
    in_beat  = '0;
  endtask

  task automatic send_window(input int ti, input int w);
    conv_pkg::out_beat_t e;
    build_window(ti, w);
    // At most one window ahead of the one in flight
    while (windows_done + 1 < windows_sent) @(posedge clk);
    for (int o = 0; o < NOCH; o++) begin
      e.data   = expected_sum(o);
      e.ch     = conv_pkg::och_idx_t'(o);
      e.win_id = conv_pkg::win_id_t'(windows_sent % 256);
      exp_q.push_back(e);
      exp_test_q.push_back(ti);
    end
    for (int t = 0; t < TAPS; t++) begin
      drive_beat(conv_pkg::BEAT_FEATURE, feat[t]);
    end
    release_bus();
    windows_sent++;
  endtask

  task automatic apply_test(input int ti);
    // Kernel writes wait for an empty engine
    if (test_kpre[ti] > 0) begin
      while (windows_done < windows_sent) @(posedge clk);
      // Partial kernel leaves the write address mid-channel
      for (int n = 0; n < test_kpre[ti]; n++) begin
        kern[n / TAPS][n % TAPS] = conv_pkg::data_t'(int'($urandom_range(15, 0)) - 8);
        drive_beat(conv_pkg::BEAT_KERNEL, kern[n / TAPS][n % TAPS]);
      end
      release_bus();
      send_window(ti, 0);
    end
    while (windows_done < windows_sent) @(posedge clk);
    build_kernel(test_ksel[ti]);
    for (int o = 0; o < NOCH; o++) begin
      for (int t = 0; t < TAPS; t++) begin
        drive_beat(conv_pkg::BEAT_KERNEL, kern[o][t]);
      end
    end
    release_bus();
    for (int w = 0; w < test_nwin[ti]; w++) begin
      send_window(ti, w);
    end
  endtask

  // Result monitor
  always @(negedge clk) begin
    conv_pkg::out_beat_t e;
    int                  ti;
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected out_valid with no result pending (ch %0d, win %0d)",
                 out_beat.ch, out_beat.win_id);
      end else begin
        e  = exp_q.pop_front();
        ti = exp_test_q.pop_front();
        checks++;
        if (out_beat != e) begin
          errors++;
          $display("** Error [%s] expected %0d ch %0d win %0d, actual %0d ch %0d win %0d",
                   test_name[ti], e.data, e.ch, e.win_id,
                   out_beat.data, out_beat.ch, out_beat.win_id);
        end
        out_cnt++;
        if (out_cnt % NOCH == 0) windows_done++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > limit_cycles) begin
      $display("Timeout after %0d cycles with %0d results still outstanding",
               cycle_cnt, exp_q.size());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hd1dc0ac4));
    limit_cycles = cycle_budget();
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_beat  = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Quiet outputs after reset with no input
    repeat (20) begin
      @(negedge clk);
      checks++;
      if (out_valid) begin
        errors++;
        $display("out_valid went high after reset without any input");
      end
    end

    for (int i = 0; i < NUM_TESTS; i++) begin
      apply_test(i);
    end
    while (exp_q.size() > 0) @(posedge clk);
    repeat (10) @(posedge clk); // Catch stray pulses

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* source/conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Sample, weight and result width
`define CONV_DATA_W 16

// Accumulator width per MAC lane
`define CONV_ACC_W 32

// Kernel taps per window (3x3)
`define CONV_TAPS 9

// Output channels, one MAC lane each
`define CONV_NUM_OCH 4

// Window id carried on every result
`define CONV_WIN_ID_W 8

`endif

/* source/conv_ctrl.sv */
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  conv_pkg::in_beat_t in_beat,
  output logic               kmem_we,
  output conv_pkg::kaddr_t   kmem_waddr,
  output logic               win_we,
  output conv_pkg::tap_idx_t win_widx,
  output logic               win_swap,
  output conv_pkg::tap_idx_t tap,
  output logic               mac_clear,
  output logic               mac_acc,
  output logic               mac_latch,
  output conv_pkg::och_idx_t drain_ch,
  output logic               out_valid,
  output conv_pkg::win_id_t  win_id
);

  localparam conv_pkg::tap_idx_t LAST_TAP   = conv_pkg::tap_idx_t'(`CONV_TAPS - 1);
  localparam conv_pkg::tap_idx_t LATCH_STEP = conv_pkg::tap_idx_t'(`CONV_TAPS);
  localparam conv_pkg::och_idx_t LAST_CH    = conv_pkg::och_idx_t'(`CONV_NUM_OCH - 1);
  localparam conv_pkg::kaddr_t   LAST_KADDR =
    conv_pkg::kaddr_t'(`CONV_NUM_OCH * `CONV_TAPS - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COMPUTE, // Nine taps, then one latch step
    ST_DRAIN    // One result per channel
  } state_t;

  state_t             state, state_nxt;
  conv_pkg::tap_idx_t tap_cnt;
  conv_pkg::och_idx_t ch_cnt;
  conv_pkg::tap_idx_t fcnt;         // Next feature slot
  conv_pkg::kaddr_t   kcnt;         // Next kernel address
  logic               next_full;    // Next window holds nine samples
  logic               last_feature; // Previous beat was a feature

  // Beat routing
  assign kmem_we  = in_valid && (in_beat.kind == conv_pkg::BEAT_KERNEL);
  assign win_we   = in_valid && (in_beat.kind == conv_pkg::BEAT_FEATURE);
  assign win_widx = fcnt;

  // A kernel after feature traffic starts over at address 0
  assign kmem_waddr = last_feature ? '0 : kcnt;

  // Swap as soon as a full window waits and the engine is free
  assign win_swap = (state == ST_IDLE) && next_full;

  assign tap       = tap_cnt;
  assign mac_acc   = (state == ST_COMPUTE) && (tap_cnt <= LAST_TAP);
  assign mac_clear = mac_acc && (tap_cnt == '0);
  assign mac_latch = (state == ST_COMPUTE) && (tap_cnt == LATCH_STEP);
  assign drain_ch  = ch_cnt;
  assign out_valid = (state == ST_DRAIN);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (next_full) state_nxt = ST_COMPUTE;
      end
      ST_COMPUTE: begin
        if (tap_cnt == LATCH_STEP) state_nxt = ST_DRAIN;
      end
      ST_DRAIN: begin
        if (ch_cnt == LAST_CH) state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      tap_cnt <= '0;
      ch_cnt  <= '0;
      win_id  <= '0;
    end else begin
      state <= state_nxt;
      case (state)
        ST_IDLE: begin
          tap_cnt <= '0;
          ch_cnt  <= '0;
        end
        ST_COMPUTE: begin
          tap_cnt <= tap_cnt + 1'b1;
        end
        ST_DRAIN: begin
          ch_cnt <= ch_cnt + 1'b1;
          if (ch_cnt == LAST_CH) win_id <= win_id + 1'b1; // Window done
        end
        default: begin
          tap_cnt <= '0;
          ch_cnt  <= '0;
        end
      endcase
    end
  end

  // Write position counters and the pending window flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fcnt         <= '0;
      kcnt         <= '0;
      next_full    <= 1'b0;
      last_feature <= 1'b0;
    end else begin
      if (kmem_we) begin
        kcnt         <= (kmem_waddr == LAST_KADDR) ? '0 : kmem_waddr + 1'b1;
        last_feature <= 1'b0;
      end
      if (win_we) begin
        fcnt         <= (fcnt == LAST_TAP) ? '0 : fcnt + 1'b1;
        last_feature <= 1'b1;
      end
      if (win_we && (fcnt == LAST_TAP)) begin
        next_full <= 1'b1;
      end else if (win_swap) begin
        next_full <= 1'b0;
      end
    end
  end

endmodule

/* source/conv_pkg.sv */
`include "conv_consts.svh"

package conv_pkg;

  // Data path words
  typedef logic signed [`CONV_DATA_W-1:0] data_t;
  typedef logic signed [`CONV_ACC_W-1:0]  acc_t;

  // Index types
  typedef logic [$clog2(`CONV_TAPS+1)-1:0]          tap_idx_t; // TAPS is the latch step
  typedef logic [$clog2(`CONV_NUM_OCH)-1:0]         och_idx_t;
  typedef logic [$clog2(`CONV_NUM_OCH*`CONV_TAPS)-1:0] kaddr_t;  // Flat kernel address
  typedef logic [`CONV_WIN_ID_W-1:0]                win_id_t;

  // One weight per MAC lane
  typedef data_t [`CONV_NUM_OCH-1:0] weight_vec_t;

  typedef enum logic {
    BEAT_FEATURE = 1'b0,
    BEAT_KERNEL  = 1'b1
  } beat_kind_t;

  // Host input word
  typedef struct packed {
    beat_kind_t kind;
    data_t      data;
  } in_beat_t;

  // Result word
  typedef struct packed {
    data_t    data;
    och_idx_t ch;
    win_id_t  win_id;
  } out_beat_t;

endpackage

/* source/conv_top.sv */
`timescale 1ns/10ps

module conv_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  conv_pkg::in_beat_t  in_beat,
  output logic                out_valid,
  output conv_pkg::out_beat_t out_beat
);

  // Kernel write side
  logic             kmem_we;
  conv_pkg::kaddr_t kmem_waddr;

  // Feature window control
  logic               win_we;
  conv_pkg::tap_idx_t win_widx;
  logic               win_swap;
  conv_pkg::tap_idx_t tap;

  // MAC control
  logic               mac_clear;
  logic               mac_acc;
  logic               mac_latch;
  conv_pkg::och_idx_t drain_ch;
  conv_pkg::win_id_t  win_id;

  // Read data toward the lanes
  conv_pkg::weight_vec_t weights;
  conv_pkg::data_t       feature;

  conv_ctrl i_conv_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .kmem_we    (kmem_we),
    .kmem_waddr (kmem_waddr),
    .win_we     (win_we),
    .win_widx   (win_widx),
    .win_swap   (win_swap),
    .tap        (tap),
    .mac_clear  (mac_clear),
    .mac_acc    (mac_acc),
    .mac_latch  (mac_latch),
    .drain_ch   (drain_ch),
    .out_valid  (out_valid),
    .win_id     (win_id)
  );

  kernel_mem i_kernel_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (kmem_we),
    .waddr   (kmem_waddr),
    .wdata   (in_beat.data),
    .tap     (tap),
    .weights (weights)
  );

  window_buffer i_window_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (win_we),
    .widx    (win_widx),
    .wdata   (in_beat.data),
    .swap    (win_swap),
    .tap     (tap),
    .feature (feature)
  );

  mac_array i_mac_array (
    .clk      (clk),
    .rst_n    (rst_n),
    .feature  (feature),
    .weights  (weights),
    .clear    (mac_clear),
    .acc      (mac_acc),
    .latch    (mac_latch),
    .drain_ch (drain_ch),
    .win_id   (win_id),
    .result   (out_beat)
  );

endmodule

/* source/kernel_mem.sv */
`timescale 1ns/10ps
`include "conv_consts.svh"

module kernel_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  we,
  input  conv_pkg::kaddr_t      waddr,
  input  conv_pkg::data_t       wdata,
  input  conv_pkg::tap_idx_t    tap,
  output conv_pkg::weight_vec_t weights
);

  localparam int DEPTH = `CONV_NUM_OCH * `CONV_TAPS;

  // Channel-major, nine taps per channel
  conv_pkg::data_t mem_q [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < DEPTH; k++) begin
        mem_q[k] <= '0;
      end
    end else if (we) begin
      mem_q[waddr] <= wdata;
    end
  end

  // Same tap for every lane, each from its own channel row
  always_comb begin
    for (int o = 0; o < `CONV_NUM_OCH; o++) begin
      if (int'(tap) < `CONV_TAPS) begin
        weights[o] = mem_q[o * `CONV_TAPS + int'(tap)];
      end else begin
        weights[o] = '0; // Latch step, lanes are idle
      end
    end
  end

endmodule

/* source/mac_array.sv */
`timescale 1ns/10ps
`include "conv_consts.svh"

module mac_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  conv_pkg::data_t       feature,
  input  conv_pkg::weight_vec_t weights,
  input  logic                  clear,
  input  logic                  acc,
  input  logic                  latch,
  input  conv_pkg::och_idx_t    drain_ch,
  input  conv_pkg::win_id_t     win_id,
  output conv_pkg::out_beat_t   result
);

  // Signed 16-bit limits in accumulator width
  localparam conv_pkg::acc_t SAT_MAX =
    conv_pkg::acc_t'((2 ** (`CONV_DATA_W - 1)) - 1);
  localparam conv_pkg::acc_t SAT_MIN =
    -conv_pkg::acc_t'(2 ** (`CONV_DATA_W - 1));

  conv_pkg::acc_t  prod  [`CONV_NUM_OCH];
  conv_pkg::acc_t  acc_q [`CONV_NUM_OCH];
  conv_pkg::data_t bank_q[`CONV_NUM_OCH]; // Latched results, read during drain

  function automatic conv_pkg::data_t saturate(input conv_pkg::acc_t v);
    conv_pkg::data_t r;
    if (v > SAT_MAX) begin
      r = conv_pkg::data_t'(SAT_MAX);
    end else if (v < SAT_MIN) begin
      r = conv_pkg::data_t'(SAT_MIN);
    end else begin
      r = conv_pkg::data_t'(v);
    end
    return r;
  endfunction

  // Shared feature times each lane's weight
  always_comb begin
    for (int i = 0; i < `CONV_NUM_OCH; i++) begin
      prod[i] = conv_pkg::acc_t'(feature) * conv_pkg::acc_t'($signed(weights[i]));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CONV_NUM_OCH; i++) begin
        acc_q[i]  <= '0;
        bank_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `CONV_NUM_OCH; i++) begin
        if (acc) begin
          acc_q[i] <= clear ? prod[i] : acc_q[i] + prod[i]; // First tap restarts the sum
        end
        if (latch) begin
          bank_q[i] <= saturate(acc_q[i]);
        end
      end
    end
  end

  // One channel per drain cycle
  always_comb begin
    result.data   = bank_q[drain_ch];
    result.ch     = drain_ch;
    result.win_id = win_id;
  end

endmodule

/* source/window_buffer.sv */
`timescale 1ns/10ps
`include "conv_consts.svh"

module window_buffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               we,
  input  conv_pkg::tap_idx_t widx,
  input  conv_pkg::data_t    wdata,
  input  logic               swap,
  input  conv_pkg::tap_idx_t tap,
  output conv_pkg::data_t    feature
);

  conv_pkg::data_t next_q [`CONV_TAPS]; // Loaded by the host
  conv_pkg::data_t cur_q  [`CONV_TAPS]; // Read by the MAC lanes

  // Next window fills in tap order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < `CONV_TAPS; k++) begin
        next_q[k] <= '0;
      end
    end else if (we) begin
      next_q[widx] <= wdata;
    end
  end

  // Whole window moves over in one edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < `CONV_TAPS; k++) begin
        cur_q[k] <= '0;
      end
    end else if (swap) begin
      for (int k = 0; k < `CONV_TAPS; k++) begin
        cur_q[k] <= next_q[k];
      end
    end
  end

  // Tap select on the current window
  always_comb begin
    if (int'(tap) < `CONV_TAPS) begin
      feature = cur_q[tap];
    end else begin
      feature = '0;
    end
  end

endmodule
